/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Physical register file size
`define PR_COUNT            64
`define LOG_PR_COUNT        6

// Register banks
// A register's bank is the low bits of its index
`define PRF_BANK_COUNT      4
`define LOG_PRF_BANK_COUNT  2

`endif

/* core_types_pkg.sv */
`include "core_settings.svh"

package core_types_pkg;

    // ------------------------------
    // ALU opcodes
    // ------------------------------

    // Codes not listed here pass B through
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_t;

    // ------------------------------
    // Register file types
    // ------------------------------

    typedef logic [`LOG_PR_COUNT-1:0]       pr_idx_t;
    typedef logic [`LOG_PRF_BANK_COUNT-1:0] bank_idx_t;

    typedef logic [31:0] word_t;

endpackage

/* prf_read_if.sv */
`include "core_settings.svh"

interface prf_read_if;
    import core_types_pkg::*;

    // Operand read results, one level per operand
    logic A_read_valid;
    logic B_read_valid;

    // Read port output of every bank
    word_t [`PRF_BANK_COUNT-1:0] read_data_by_bank;

    // Writeback data shown on the bank it targets
    word_t [`PRF_BANK_COUNT-1:0] forward_data_by_bank;

    modport prf (
        output A_read_valid,
        output B_read_valid,
        output read_data_by_bank,
        output forward_data_by_bank
    );

    modport alu (
        input A_read_valid,
        input B_read_valid,
        input read_data_by_bank,
        input forward_data_by_bank
    );

endinterface

/* prf_banked.sv */
`include "core_settings.svh"

module prf_banked (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    A_read_req,
    input  logic                    B_read_req,
    input  core_types_pkg::pr_idx_t A_PR,
    input  core_types_pkg::pr_idx_t B_PR,
    input  logic                    accept,
    input  logic                    WB_valid,
    input  core_types_pkg::pr_idx_t WB_PR,
    input  core_types_pkg::word_t   WB_data,
    prf_read_if.prf                 rd
);
    import core_types_pkg::*;

    localparam int ROW_COUNT = `PR_COUNT / `PRF_BANK_COUNT;
    localparam int ROW_W     = `LOG_PR_COUNT - `LOG_PRF_BANK_COUNT;

    typedef logic [ROW_W-1:0] row_idx_t;

    bank_idx_t wb_bank;
    row_idx_t  wb_row;

    logic      a_pending;
    logic      b_pending;
    logic      a_served;
    logic      b_served;
    bank_idx_t a_bank_q;
    bank_idx_t b_bank_q;
    row_idx_t  a_row_q;
    row_idx_t  b_row_q;
    word_t     a_data_q;
    word_t     b_data_q;
    logic      a_serve;
    logic      b_serve;

    word_t [`PRF_BANK_COUNT-1:0] bank_word;

    assign wb_bank = WB_PR[`LOG_PRF_BANK_COUNT-1:0];
    assign wb_row  = WB_PR[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];

    // ------------------------------
    // Register banks
    // ------------------------------

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
        word_t    rows [ROW_COUNT];
        logic     wr_en;
        row_idx_t port_row;

        assign wr_en = WB_valid && (wb_bank == bank_idx_t'(b));

        // One port per bank, A and B only share a bank on the same register
        assign port_row     = (a_pending && a_bank_q == bank_idx_t'(b)) ? a_row_q : b_row_q;
        assign bank_word[b] = rows[port_row];

        always_ff @(posedge CLK or negedge nRST) begin
            if (!nRST) begin
                for (int r = 0; r < ROW_COUNT; r++) begin
                    rows[r] <= '0;
                end
            end else if (wr_en) begin
                rows[wb_row] <= WB_data;
            end
        end
    end

    // ------------------------------
    // Pending reads
    // ------------------------------

    // A write to the same bank blocks the read for this cycle
    assign a_serve = a_pending && !(WB_valid && wb_bank == a_bank_q);
    assign b_serve = b_pending && !(WB_valid && wb_bank == b_bank_q);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            a_pending <= 1'b0;
            b_pending <= 1'b0;
            a_served  <= 1'b0;
            b_served  <= 1'b0;
            a_bank_q  <= '0;
            b_bank_q  <= '0;
            a_row_q   <= '0;
            b_row_q   <= '0;
        end else if (accept) begin
            a_pending <= A_read_req;
            b_pending <= B_read_req;
            a_served  <= 1'b0;
            b_served  <= 1'b0;
            a_bank_q  <= A_PR[`LOG_PRF_BANK_COUNT-1:0];
            b_bank_q  <= B_PR[`LOG_PRF_BANK_COUNT-1:0];
            a_row_q   <= A_PR[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];
            b_row_q   <= B_PR[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT];
        end else begin
            if (a_serve) begin
                a_pending <= 1'b0;
                a_served  <= 1'b1;
            end
            if (b_serve) begin
                b_pending <= 1'b0;
                b_served  <= 1'b1;
            end
        end
    end

    // Served words held until the next issue
    always_ff @(posedge CLK) begin
        if (a_serve) begin
            a_data_q <= bank_word[a_bank_q];
        end
        if (b_serve) begin
            b_data_q <= bank_word[b_bank_q];
        end
    end

    assign rd.A_read_valid = a_serve || a_served;
    assign rd.B_read_valid = b_serve || b_served;

    always_comb begin
        rd.read_data_by_bank = '0;
        if (a_served) begin
            rd.read_data_by_bank[a_bank_q] = a_data_q;
        end
        if (a_serve) begin
            rd.read_data_by_bank[a_bank_q] = bank_word[a_bank_q];
        end
        if (b_served) begin
            rd.read_data_by_bank[b_bank_q] = b_data_q;
        end
        if (b_serve) begin
            rd.read_data_by_bank[b_bank_q] = bank_word[b_bank_q];
        end
    end

    // Forwarding bus
    always_comb begin
        rd.forward_data_by_bank = '0;
        if (WB_valid) begin
            rd.forward_data_by_bank[wb_bank] = WB_data;
        end
    end

endmodule

/* alu_pipeline.sv */
`include "core_settings.svh"

module alu_pipeline (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    valid,
    input  core_types_pkg::alu_op_t op,
    input  logic                    is_imm,
    input  core_types_pkg::word_t   imm,
    input  logic                    A_unneeded,
    input  logic                    A_forward,
    input  core_types_pkg::pr_idx_t A_PR,
    input  logic                    B_forward,
    input  core_types_pkg::pr_idx_t B_PR,
    input  core_types_pkg::pr_idx_t dest_PR,
    prf_read_if.alu                 rd,
    output logic                    ready,
    output logic                    WB_valid,
    output core_types_pkg::word_t   WB_data,
    output core_types_pkg::pr_idx_t WB_PR
);
    import core_types_pkg::*;

    // ------------------------------
    // Operand collection
    // ------------------------------

    logic      valid_oc;
    logic      is_imm_oc;
    logic      a_unneeded_oc;
    logic      a_forward_oc;
    logic      b_forward_oc;
    alu_op_t   op_oc;
    word_t     imm_oc;
    bank_idx_t a_bank_oc;
    bank_idx_t b_bank_oc;
    pr_idx_t   dest_pr_oc;

    logic      launch_ready;
    logic      launch_oc;
    word_t     a_oc;
    word_t     b_oc;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_oc      <= 1'b0;
            is_imm_oc     <= 1'b0;
            a_unneeded_oc <= 1'b0;
            a_forward_oc  <= 1'b0;
            b_forward_oc  <= 1'b0;
        end else if (ready) begin
            valid_oc      <= valid;
            is_imm_oc     <= is_imm;
            a_unneeded_oc <= A_unneeded;
            a_forward_oc  <= A_forward;
            b_forward_oc  <= B_forward;
        end
    end

    always_ff @(posedge CLK) begin
        if (ready) begin
            op_oc      <= op;
            imm_oc     <= imm;
            a_bank_oc  <= A_PR[`LOG_PRF_BANK_COUNT-1:0];
            b_bank_oc  <= B_PR[`LOG_PRF_BANK_COUNT-1:0];
            dest_pr_oc <= dest_PR;
        end
    end

    // Both operands must be in hand before launch
    assign launch_ready = (a_unneeded_oc || a_forward_oc || rd.A_read_valid)
                       && (is_imm_oc || b_forward_oc || rd.B_read_valid);
    assign launch_oc    = valid_oc && launch_ready;
    assign ready        = !valid_oc || launch_ready;

    assign a_oc = a_forward_oc ? rd.forward_data_by_bank[a_bank_oc]
                               : rd.read_data_by_bank[a_bank_oc];

    always_comb begin
        if (is_imm_oc) begin
            b_oc = imm_oc;
        end else if (b_forward_oc) begin
            b_oc = rd.forward_data_by_bank[b_bank_oc];
        end else begin
            b_oc = rd.read_data_by_bank[b_bank_oc];
        end
    end

    // ------------------------------
    // Execute
    // ------------------------------

    logic     valid_ex;
    alu_op_t  op_ex;
    word_t    a_ex;
    word_t    b_ex;
    pr_idx_t  dest_pr_ex;
    logic [4:0] shamt;
    word_t    alu_result;

    logic     valid_res;
    word_t    result_res;
    pr_idx_t  dest_pr_res;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_ex <= 1'b0;
        end else begin
            valid_ex <= launch_oc;
        end
    end

    always_ff @(posedge CLK) begin
        op_ex      <= op_oc;
        a_ex       <= a_oc;
        b_ex       <= b_oc;
        dest_pr_ex <= dest_pr_oc;
    end

    assign shamt = b_ex[4:0];

    always_comb begin
        case (op_ex)
            ALU_ADD:    alu_result = a_ex + b_ex;
            ALU_SLL:    alu_result = a_ex << shamt;
            ALU_SLT:    alu_result = {31'b0, $signed(a_ex) < $signed(b_ex)};
            ALU_SLTU:   alu_result = {31'b0, a_ex < b_ex};
            ALU_XOR:    alu_result = a_ex ^ b_ex;
            ALU_SRL:    alu_result = a_ex >> shamt;
            ALU_OR:     alu_result = a_ex | b_ex;
            ALU_AND:    alu_result = a_ex & b_ex;
            ALU_SUB:    alu_result = a_ex - b_ex;
            ALU_SRA:    alu_result = $signed(a_ex) >>> shamt;
            ALU_PASS_B: alu_result = b_ex;
            default:    alu_result = b_ex;
        endcase
    end

    // Result registered at the end of execute
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_res <= 1'b0;
        end else begin
            valid_res <= valid_ex;
        end
    end

    always_ff @(posedge CLK) begin
        result_res  <= alu_result;
        dest_pr_res <= dest_pr_ex;
    end

    // ------------------------------
    // Writeback
    // ------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            WB_valid <= 1'b0;
        end else begin
            WB_valid <= valid_res;
        end
    end

    always_ff @(posedge CLK) begin
        WB_data <= result_res;
        WB_PR   <= dest_pr_res;
    end

endmodule

/* alu_core.sv */
module alu_core (
    input  logic                    CLK,
    input  logic                    nRST,

    // Issue
    input  logic                    valid,
    input  core_types_pkg::alu_op_t op,
    input  logic                    is_imm,
    input  core_types_pkg::word_t   imm,
    input  logic                    A_unneeded,
    input  logic                    A_forward,
    input  logic                    A_read_req,
    input  core_types_pkg::pr_idx_t A_PR,
    input  logic                    B_forward,
    input  logic                    B_read_req,
    input  core_types_pkg::pr_idx_t B_PR,
    input  core_types_pkg::pr_idx_t dest_PR,
    output logic                    ready,

    // Writeback
    output logic                    WB_valid,
    output core_types_pkg::word_t   WB_data,
    output core_types_pkg::pr_idx_t WB_PR
);

    logic accept;

    prf_read_if rd_bus ();

    // Issue taken at this edge
    assign accept = valid && ready;

    prf_banked u_prf (
        .CLK        (CLK),
        .nRST       (nRST),
        .A_read_req (A_read_req),
        .B_read_req (B_read_req),
        .A_PR       (A_PR),
        .B_PR       (B_PR),
        .accept     (accept),
        .WB_valid   (WB_valid),
        .WB_PR      (WB_PR),
        .WB_data    (WB_data),
        .rd         (rd_bus.prf)
    );

    alu_pipeline u_alu (
        .CLK        (CLK),
        .nRST       (nRST),
        .valid      (valid),
        .op         (op),
        .is_imm     (is_imm),
        .imm        (imm),
        .A_unneeded (A_unneeded),
        .A_forward  (A_forward),
        .A_PR       (A_PR),
        .B_forward  (B_forward),
        .B_PR       (B_PR),
        .dest_PR    (dest_PR),
        .rd         (rd_bus.alu),
        .ready      (ready),
        .WB_valid   (WB_valid),
        .WB_data    (WB_data),
        .WB_PR      (WB_PR)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2) CLK = ~CLK;
        end
    end

    // Reset released just after an edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

/* tb_alu_core.sv */
`include "core_settings.svh"

module tb_alu_core;
    timeunit 1ns;
    timeprecision 100ps;
    import core_types_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SWEEP_OPS    = 16;
    localparam int RANDOM_OPS   = 80;
    localparam int TOTAL_OPS    = `PR_COUNT + SWEEP_OPS + RANDOM_OPS + 8 + 16;
    localparam longint WATCHDOG_NS = longint'((TOTAL_OPS * 8 + RESET_CYCLES) * CLK_PERIOD);

    logic    CLK;
    logic    nRST;
    logic    valid;
    alu_op_t op;
    logic    is_imm;
    word_t   imm;
    logic    A_unneeded;
    logic    A_forward;
    logic    A_read_req;
    pr_idx_t A_PR;
    logic    B_forward;
    logic    B_read_req;
    pr_idx_t B_PR;
    pr_idx_t dest_PR;
    logic    ready;
    logic    WB_valid;
    word_t   WB_data;
    pr_idx_t WB_PR;

    // Model state shared by issue side and monitor
    word_t   model_rf [`PR_COUNT];
    int      busy [`PR_COUNT];
    word_t   exp_data [$];
    pr_idx_t exp_pr [$];
    int      exp_edge [$];
    int      exp_stalls [$];
    string   exp_test [$];
    string   cur_test = "reset";
    int      edge_count = 0;
    int      stall_count = 0;
    int      accept_total = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    alu_core UUT (
        .CLK        (CLK),
        .nRST       (nRST),
        .valid      (valid),
        .op         (op),
        .is_imm     (is_imm),
        .imm        (imm),
        .A_unneeded (A_unneeded),
        .A_forward  (A_forward),
        .A_read_req (A_read_req),
        .A_PR       (A_PR),
        .B_forward  (B_forward),
        .B_read_req (B_read_req),
        .B_PR       (B_PR),
        .dest_PR    (dest_PR),
        .ready      (ready),
        .WB_valid   (WB_valid),
        .WB_data    (WB_data),
        .WB_PR      (WB_PR)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // ------------------------------
    // Reference rules
    // ------------------------------

    function automatic word_t expect_result(input logic [3:0] code, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      res;
        sh = b[4:0];
        case (code)
            4'b0000: res = a + b;
            4'b0001: res = a << sh;
            4'b0010: res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            4'b0011: res = {31'b0, a < b};
            4'b0100: res = a ^ b;
            4'b0101: res = a >> sh;
            4'b0110: res = a | b;
            4'b0111: res = a & b;
            4'b1000: res = a + ~b + 32'd1;
            4'b1101: begin
                res = a >> sh;
                // Sign fill for the vacated upper bits
                if (a[31]) begin
                    res = res | ~(32'hffff_ffff >> sh);
                end
            end
            default: res = b;
        endcase
        return res;
    endfunction

    function automatic logic uses_a(input logic [3:0] code);
        return code <= 4'b1000 || code == 4'b1101;
    endfunction

    function automatic pr_idx_t pick_free_reg();
        pr_idx_t r;
        r = pr_idx_t'($urandom_range(`PR_COUNT - 1));
        while (busy[r] != 0) begin
            r = pr_idx_t'($urandom_range(`PR_COUNT - 1));
        end
        return r;
    endfunction

    // ------------------------------
    // Monitor and checks
    // ------------------------------

    always @(posedge CLK) begin
        word_t a_val;
        word_t b_val;
        edge_count++;
        if (accept_total == 0) begin
            assert (ready === 1'b1 && WB_valid === 1'b0)
                else fail_now("ready low or WB_valid high before the first op");
        end
        if (WB_valid) begin
            assert (exp_data.size() > 0)
                else fail_now("writeback seen with no op outstanding");
            assert (WB_data === exp_data[0])
                else fail_now($sformatf("mismatch %s WB_data expected %h actual %h",
                                        exp_test[0], exp_data[0], WB_data));
            assert (WB_PR === exp_pr[0])
                else fail_now($sformatf("mismatch %s WB_PR expected %0d actual %0d",
                                        exp_test[0], exp_pr[0], WB_PR));
            assert (edge_count - 1 - exp_edge[0] == 3 + exp_stalls[0])
                else fail_now($sformatf("mismatch %s latency expected %0d actual %0d",
                                        exp_test[0], 3 + exp_stalls[0],
                                        edge_count - 1 - exp_edge[0]));
            busy[WB_PR]--;
            void'(exp_data.pop_front());
            void'(exp_pr.pop_front());
            void'(exp_edge.pop_front());
            void'(exp_stalls.pop_front());
            void'(exp_test.pop_front());
        end
        if (valid && ready) begin
            a_val = model_rf[A_PR];
            b_val = is_imm ? imm : model_rf[B_PR];
            exp_data.push_back(expect_result(op, a_val, b_val));
            exp_pr.push_back(dest_PR);
            exp_edge.push_back(edge_count);
            exp_stalls.push_back(0);
            exp_test.push_back(cur_test);
            model_rf[dest_PR] = expect_result(op, a_val, b_val);
            accept_total++;
        end else if (!ready) begin
            // The stalled op is always the newest one
            assert (exp_stalls.size() > 0)
                else fail_now("ready low with no op in operand collection");
            exp_stalls[exp_stalls.size() - 1]++;
            stall_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the run finished");
    end

    // ------------------------------
    // Issue model
    // ------------------------------

    task automatic send_op(input logic [3:0] code, input logic imm_sel, input word_t imm_val,
                           input logic a_unn, input logic a_fwd, input pr_idx_t a_pr,
                           input pr_idx_t b_pr, input pr_idx_t dst, output longint t_acc);
        #1;
        valid      = 1'b1;
        op         = alu_op_t'(code);
        is_imm     = imm_sel;
        imm        = imm_val;
        A_unneeded = a_unn;
        A_forward  = a_fwd;
        A_read_req = !a_unn && !a_fwd;
        A_PR       = a_pr;
        B_forward  = 1'b0;
        B_read_req = !imm_sel;
        B_PR       = b_pr;
        dest_PR    = dst;
        do @(posedge CLK); while (!ready);
        t_acc = $time;
        // Destination stays off limits as a source until its writeback
        busy[dst]++;
    endtask

    task automatic idle(input int cycles);
        #1 valid = 1'b0;
        repeat (cycles) @(posedge CLK);
    endtask

    task automatic wait_drain();
        #1 valid = 1'b0;
        do @(posedge CLK); while (exp_data.size() != 0);
    endtask

    initial begin
        longint     t_p;
        longint     t_d;
        longint     t_x;
        pr_idx_t    r;
        pr_idx_t    a_pr;
        pr_idx_t    b_pr;
        logic [3:0] code;
        logic       imm_sel;
        logic       a_unn;
        int         stalls_before;
        void'($urandom(32'h60ff_2588));
        valid      = 1'b0;
        op         = ALU_ADD;
        is_imm     = 1'b0;
        imm        = '0;
        A_unneeded = 1'b0;
        A_forward  = 1'b0;
        A_read_req = 1'b0;
        A_PR       = '0;
        B_forward  = 1'b0;
        B_read_req = 1'b0;
        B_PR       = '0;
        dest_PR    = '0;
        for (int i = 0; i < `PR_COUNT; i++) begin
            model_rf[i] = '0;
            busy[i]     = 0;
        end
        @(posedge nRST);
        @(posedge CLK);
        idle(4);

        cur_test = "load";
        for (int i = 0; i < `PR_COUNT; i++) begin
            send_op(4'b1111, 1'b1, $urandom(), 1'b1, 1'b0, '0, '0, pr_idx_t'(i), t_x);
        end
        wait_drain();

        // Every code once, then random codes
        cur_test = "random";
        for (int n = 0; n < SWEEP_OPS + RANDOM_OPS; n++) begin
            code    = (n < SWEEP_OPS) ? 4'(n) : 4'($urandom_range(15));
            a_unn   = !uses_a(code) && $urandom_range(1) == 1;
            imm_sel = $urandom_range(1) == 1;
            a_pr    = pick_free_reg();
            b_pr    = pick_free_reg();
            // One bank port, so no two rows of one bank
            if (!a_unn && !imm_sel && b_pr[1:0] == a_pr[1:0]) begin
                b_pr = a_pr;
            end
            send_op(code, imm_sel, $urandom(), a_unn, 1'b0, a_pr, b_pr,
                    pr_idx_t'($urandom_range(`PR_COUNT - 1)), t_x);
        end
        wait_drain();

        // Read of a bank while its writeback lands
        cur_test = "backpressure";
        r = pr_idx_t'($urandom_range(`PR_COUNT - 1));
        stalls_before = stall_count;
        send_op(4'b1111, 1'b1, $urandom(), 1'b1, 1'b0, '0, '0, r, t_x);
        send_op(4'b1111, 1'b1, $urandom(), 1'b1, 1'b0, '0, '0, r ^ 6'd1, t_x);
        send_op(4'b1111, 1'b1, $urandom(), 1'b1, 1'b0, '0, '0, r ^ 6'd2, t_x);
        send_op(4'b0000, 1'b1, $urandom(), 1'b0, 1'b0, r ^ 6'd4, '0, r ^ 6'd3, t_x);
        wait_drain();
        assert (stall_count > stalls_before)
            else fail_now("ready did not drop on a bank write conflict");

        cur_test = "forward";
        r = pr_idx_t'($urandom_range(`PR_COUNT - 1));
        send_op(4'b1111, 1'b1, ~model_rf[r], 1'b1, 1'b0, '0, '0, r, t_p);
        send_op(4'b1111, 1'b1, $urandom(), 1'b1, 1'b0, '0, '0, r ^ 6'd1, t_x);
        send_op(4'b1111, 1'b1, $urandom(), 1'b1, 1'b0, '0, '0, r ^ 6'd2, t_x);
        send_op(4'b0000, 1'b1, $urandom(), 1'b0, 1'b1, r, '0, r ^ 6'd3, t_d);
        assert (t_d - t_p == longint'(3 * CLK_PERIOD))
            else fail_now("forwarded op not accepted three edges after its producer");
        wait_drain();

        // Quiet tail, any stray writeback fails in the monitor
        cur_test = "drain";
        idle(10);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
core_types_pkg.sv
prf_read_if.sv
prf_banked.sv
alu_pipeline.sv
alu_core.sv
tb_clock_gen.sv
tb_alu_core.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module tb_alu_core --Mdir $(OBJ_DIR) -o Vtb_alu_core

run: build
	./$(OBJ_DIR)/Vtb_alu_core

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps +incdir+. \
		core_types_pkg.sv prf_read_if.sv prf_banked.sv alu_pipeline.sv alu_core.sv \
		--top-module alu_core

clean:
	rm -rf $(OBJ_DIR)
